//--- Makefile
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

//--- cpu_top.f
design/rv_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_sequencer.sv
design/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

//--- design/cpu_ctrl_pkg.sv
// Core control constants
// Memory widths, ALU function codes, boot vectors and sequencer states
package cpu_ctrl_pkg;

   localparam int ADDR_W = 16;

   // ALU function code is {alternate bit, funct3}
   localparam int ALU_FN_W = 4;
   localparam logic [ALU_FN_W-1:0] ALU_ADD  = 4'b0000;
   localparam logic [ALU_FN_W-1:0] ALU_SUB  = 4'b1000;
   localparam logic [ALU_FN_W-1:0] ALU_SLL  = 4'b0001;
   localparam logic [ALU_FN_W-1:0] ALU_SLT  = 4'b0010;
   localparam logic [ALU_FN_W-1:0] ALU_SLTU = 4'b0011;
   localparam logic [ALU_FN_W-1:0] ALU_XOR  = 4'b0100;
   localparam logic [ALU_FN_W-1:0] ALU_SRL  = 4'b0101;
   localparam logic [ALU_FN_W-1:0] ALU_SRA  = 4'b1101;
   localparam logic [ALU_FN_W-1:0] ALU_OR   = 4'b0110;
   localparam logic [ALU_FN_W-1:0] ALU_AND  = 4'b0111;

   // Boot vectors and the stack pointer register word
   localparam logic [ADDR_W-1:0] VEC_RESET   = 16'h0080;
   localparam logic [ADDR_W-1:0] VEC_SP      = 16'h0084;
   localparam logic [ADDR_W-1:0] SP_REG_ADDR = 16'h0008;

   localparam int BOOT_CYCLES = 16;
   localparam int BOOT_CNT_W  = $clog2(BOOT_CYCLES);

   typedef enum logic [3:0] {
      BOOT,
      LD_PC,
      LD_SP,
      ST_SP,
      FETCH,
      LD_RS1,
      LD_RS2,
      EXEC_BRANCH,
      LOAD,
      WRITE_RD,
      STORE,
      FAULT
   } seq_state_t;

endpackage

//--- design/cpu_top.sv
// RV32I multicycle core top level
// Decoder, ALU and sequencer on one word-wide memory port
`timescale 1ns/10ps

module cpu_top
   import rv_isa_pkg::*, cpu_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   output logic              o_rd_en,
   output logic [ADDR_W-1:0] o_addr,
   input  logic [XLEN-1:0]   i_rd_data,
   input  logic              i_rd_valid,
   output logic              o_wr_en,
   output logic [XLEN-1:0]   o_wr_data,
   output logic              o_fault
);

   logic [XLEN-1:0]      inst;
   logic [REG_IDX_W-1:0] rs1;
   logic [REG_IDX_W-1:0] rs2;
   logic [REG_IDX_W-1:0] rd;
   logic [XLEN-1:0]      imm;
   logic [ALU_FN_W-1:0]  alu_fn;
   logic                 op2_rs2;
   logic [OPCODE_W-1:0]  opcode;
   logic [2:0]           funct3;
   logic [XLEN-1:0]      rs1_val;
   logic [XLEN-1:0]      rs2_val;
   logic [XLEN-1:0]      alu_out;
   logic                 branch_taken;

   rv_decode u_decode (
      .i_inst    (inst),
      .o_rs1     (rs1),
      .o_rs2     (rs2),
      .o_rd      (rd),
      .o_imm     (imm),
      .o_alu_fn  (alu_fn),
      .o_op2_rs2 (op2_rs2),
      .o_opcode  (opcode),
      .o_funct3  (funct3)
   );

   rv_alu u_alu (
      .i_x            (rs1_val),
      .i_y            (rs2_val),
      .i_fn           (alu_fn),
      .i_funct3       (funct3),
      .o_out          (alu_out),
      .o_zero         (),
      .o_branch_taken (branch_taken)
   );

   rv_sequencer u_sequencer (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_rd_data      (i_rd_data),
      .i_rd_valid     (i_rd_valid),
      .o_rd_en        (o_rd_en),
      .o_wr_en        (o_wr_en),
      .o_addr         (o_addr),
      .o_wr_data      (o_wr_data),
      .o_fault        (o_fault),
      .o_inst         (inst),
      .i_rs1          (rs1),
      .i_rs2          (rs2),
      .i_rd           (rd),
      .i_imm          (imm),
      .i_op2_rs2      (op2_rs2),
      .i_opcode       (opcode),
      .i_alu_out      (alu_out),
      .i_branch_taken (branch_taken),
      .o_rs1_val      (rs1_val),
      .o_rs2_val      (rs2_val)
   );

endmodule

//--- design/rv_alu.sv
// RV32I integer ALU
// Ten base operations, zero flag and branch decision
`timescale 1ns/10ps

module rv_alu
   import rv_isa_pkg::*, cpu_ctrl_pkg::*;
(
   input  logic [XLEN-1:0]     i_x,
   input  logic [XLEN-1:0]     i_y,
   input  logic [ALU_FN_W-1:0] i_fn,
   input  logic [2:0]          i_funct3,
   output logic [XLEN-1:0]     o_out,
   output logic                o_zero,
   output logic                o_branch_taken
);

   logic [4:0] shamt;

   assign shamt = i_y[4:0];

   always_comb begin
      case (i_fn)
         ALU_ADD:  o_out = i_x + i_y;
         ALU_SUB:  o_out = i_x - i_y;
         ALU_SLL:  o_out = i_x << shamt;
         ALU_SLT:  o_out = {{(XLEN-1){1'b0}}, $signed(i_x) < $signed(i_y)};
         ALU_SLTU: o_out = {{(XLEN-1){1'b0}}, i_x < i_y};
         ALU_XOR:  o_out = i_x ^ i_y;
         ALU_SRL:  o_out = i_x >> shamt;
         ALU_SRA:  o_out = $unsigned($signed(i_x) >>> shamt);
         ALU_OR:   o_out = i_x | i_y;
         ALU_AND:  o_out = i_x & i_y;
         default:  o_out = '0;
      endcase
   end

   assign o_zero = (o_out == '0);

   // Equality uses the SUB result, ordering uses the SLT/SLTU bit
   always_comb begin
      case (i_funct3)
         BR_BEQ:  o_branch_taken = o_zero;
         BR_BNE:  o_branch_taken = !o_zero;
         BR_BLT:  o_branch_taken = o_out[0];
         BR_BGE:  o_branch_taken = !o_out[0];
         BR_BLTU: o_branch_taken = o_out[0];
         BR_BGEU: o_branch_taken = !o_out[0];
         default: o_branch_taken = 1'b0;
      endcase
   end

endmodule

//--- design/rv_decode.sv
// RV32I instruction decoder
// Register indices, sign-extended immediate and ALU function select
`timescale 1ns/10ps

module rv_decode
   import rv_isa_pkg::*, cpu_ctrl_pkg::*;
(
   input  logic [XLEN-1:0]      i_inst,
   output logic [REG_IDX_W-1:0] o_rs1,
   output logic [REG_IDX_W-1:0] o_rs2,
   output logic [REG_IDX_W-1:0] o_rd,
   output logic [XLEN-1:0]      o_imm,
   output logic [ALU_FN_W-1:0]  o_alu_fn,
   output logic                 o_op2_rs2,
   output logic [OPCODE_W-1:0]  o_opcode,
   output logic [2:0]           o_funct3
);

   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_b;
   logic [XLEN-1:0] imm_j;
   logic [XLEN-1:0] imm_u;

   assign o_opcode = i_inst[OPCODE_W-1:0];
   assign o_rd     = i_inst[RD_LSB +: REG_IDX_W];
   assign o_funct3 = i_inst[FUNCT3_LSB +: 3];
   assign o_rs1    = i_inst[RS1_LSB +: REG_IDX_W];
   assign o_rs2    = i_inst[RS2_LSB +: REG_IDX_W];

   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
   assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
   assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21],
                   1'b0};
   assign imm_u = {i_inst[31:12], 12'b0};

   always_comb begin
      case (o_opcode)
         OP_ALU_I, OP_LOAD, OP_JALR: o_imm = imm_i;
         OP_STORE:                   o_imm = imm_s;
         OP_BRANCH:                  o_imm = imm_b;
         OP_JAL:                     o_imm = imm_j;
         OP_LUI, OP_AUIPC:           o_imm = imm_u;
         default:                    o_imm = '0;
      endcase
   end

   always_comb begin
      o_op2_rs2 = 1'b0;
      o_alu_fn  = ALU_ADD;
      case (o_opcode)
         OP_ALU_R: begin
            o_op2_rs2 = 1'b1;
            o_alu_fn  = {i_inst[FUNCT7_ALT_BIT], o_funct3};
         end
         OP_ALU_I: begin
            // Only SRAI carries the alternate bit, in imm[10]
            if (o_funct3 == 3'h1 || o_funct3 == 3'h5)
               o_alu_fn = {imm_i[10], o_funct3};
            else
               o_alu_fn = {1'b0, o_funct3};
         end
         OP_BRANCH: begin
            o_op2_rs2 = 1'b1;
            case (o_funct3)
               BR_BLT, BR_BGE:   o_alu_fn = ALU_SLT;
               BR_BLTU, BR_BGEU: o_alu_fn = ALU_SLTU;
               default:          o_alu_fn = ALU_SUB;
            endcase
         end
         default: begin
            o_alu_fn = ALU_ADD;
         end
      endcase
   end

endmodule

//--- design/rv_isa_pkg.sv
// RV32I instruction set constants
// Major opcodes, branch funct3 codes and instruction field positions
package rv_isa_pkg;

   // Data and register index widths
   localparam int XLEN      = 32;
   localparam int REG_IDX_W = 5;
   localparam int OPCODE_W  = 7;

   // Field positions inside a 32-bit instruction
   localparam int RD_LSB         = 7;
   localparam int FUNCT3_LSB     = 12;
   localparam int RS1_LSB        = 15;
   localparam int RS2_LSB        = 20;
   localparam int FUNCT7_ALT_BIT = 30;

   // Major opcodes
   localparam logic [OPCODE_W-1:0] OP_ALU_R  = 7'b0110011;
   localparam logic [OPCODE_W-1:0] OP_ALU_I  = 7'b0010011;
   localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
   localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
   localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
   localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
   localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
   localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
   localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;

   // Branch funct3 codes
   localparam logic [2:0] BR_BEQ  = 3'h0;
   localparam logic [2:0] BR_BNE  = 3'h1;
   localparam logic [2:0] BR_BLT  = 3'h4;
   localparam logic [2:0] BR_BGE  = 3'h5;
   localparam logic [2:0] BR_BLTU = 3'h6;
   localparam logic [2:0] BR_BGEU = 3'h7;

endpackage

//--- design/rv_sequencer.sv
// Multicycle sequencer for the RV32I core
// Boot, vector loads, instruction steps and the shared memory port
`timescale 1ns/10ps

module rv_sequencer
   import rv_isa_pkg::*, cpu_ctrl_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic [XLEN-1:0]      i_rd_data,
   input  logic                 i_rd_valid,
   output logic                 o_rd_en,
   output logic                 o_wr_en,
   output logic [ADDR_W-1:0]    o_addr,
   output logic [XLEN-1:0]      o_wr_data,
   output logic                 o_fault,
   output logic [XLEN-1:0]      o_inst,
   input  logic [REG_IDX_W-1:0] i_rs1,
   input  logic [REG_IDX_W-1:0] i_rs2,
   input  logic [REG_IDX_W-1:0] i_rd,
   input  logic [XLEN-1:0]      i_imm,
   input  logic                 i_op2_rs2,
   input  logic [OPCODE_W-1:0]  i_opcode,
   input  logic [XLEN-1:0]      i_alu_out,
   input  logic                 i_branch_taken,
   output logic [XLEN-1:0]      o_rs1_val,
   output logic [XLEN-1:0]      o_rs2_val
);

   seq_state_t            state;
   logic [BOOT_CNT_W-1:0] boot_cnt;
   logic [ADDR_W-1:0]     pc;
   logic [XLEN-1:0]       inst;
   logic [XLEN-1:0]       rs1_val;
   logic [XLEN-1:0]       rs2_val;
   logic [XLEN-1:0]       mem_data;
   logic [XLEN-1:0]       rd_result;
   logic [XLEN-1:0]       pc_ext;
   logic [ADDR_W-1:0]     pc_plus4;
   logic [ADDR_W-1:0]     rs1_addr;
   logic [ADDR_W-1:0]     rs2_addr;
   logic [ADDR_W-1:0]     rd_addr;
   logic [ADDR_W-1:0]     alu_addr;

   // Register xN lives at byte address N*4
   assign rs1_addr = {{(ADDR_W-REG_IDX_W-2){1'b0}}, i_rs1, 2'b00};
   assign rs2_addr = {{(ADDR_W-REG_IDX_W-2){1'b0}}, i_rs2, 2'b00};
   assign rd_addr  = {{(ADDR_W-REG_IDX_W-2){1'b0}}, i_rd, 2'b00};
   assign alu_addr = i_alu_out[ADDR_W-1:0];
   assign pc_plus4 = pc + ADDR_W'(4);
   assign pc_ext   = {{(XLEN-ADDR_W){1'b0}}, pc};

   assign o_inst    = inst;
   assign o_rs1_val = rs1_val;
   // Operand 2 for the ALU
   assign o_rs2_val = i_op2_rs2 ? rs2_val : i_imm;
   assign o_fault   = (state == FAULT);

   always_comb begin
      case (i_opcode)
         OP_LOAD:         rd_result = mem_data;
         OP_JAL, OP_JALR: rd_result = {{(XLEN-ADDR_W){1'b0}}, pc_plus4};
         OP_LUI:          rd_result = i_imm;
         OP_AUIPC:        rd_result = pc_ext + i_imm;
         default:         rd_result = i_alu_out;
      endcase
   end

   always_comb begin
      o_rd_en   = 1'b0;
      o_wr_en   = 1'b0;
      o_addr    = '0;
      o_wr_data = '0;
      case (state)
         LD_PC:  begin o_rd_en = 1'b1; o_addr = VEC_RESET; end
         LD_SP:  begin o_rd_en = 1'b1; o_addr = VEC_SP; end
         FETCH:  begin o_rd_en = 1'b1; o_addr = pc; end
         LD_RS1: begin o_rd_en = 1'b1; o_addr = rs1_addr; end
         LD_RS2: begin o_rd_en = 1'b1; o_addr = rs2_addr; end
         LOAD:   begin o_rd_en = 1'b1; o_addr = alu_addr; end
         ST_SP: begin
            o_wr_en   = 1'b1;
            o_addr    = SP_REG_ADDR;
            o_wr_data = mem_data;
         end
         WRITE_RD: begin
            o_wr_en   = (i_rd != '0);
            o_addr    = rd_addr;
            o_wr_data = rd_result;
         end
         STORE: begin
            // x0 occupies the first word, keep it zero
            o_wr_en   = (alu_addr[ADDR_W-1:2] != '0);
            o_addr    = alu_addr;
            o_wr_data = rs2_val;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= BOOT;
         boot_cnt <= '0;
      end else begin
         case (state)
            BOOT: begin
               boot_cnt <= boot_cnt + 1'b1;
               if (boot_cnt == BOOT_CNT_W'(BOOT_CYCLES - 1))
                  state <= LD_PC;
            end
            LD_PC: begin
               if (i_rd_valid) begin
                  pc    <= i_rd_data[ADDR_W-1:0];
                  state <= LD_SP;
               end
            end
            LD_SP: begin
               if (i_rd_valid) begin
                  mem_data <= i_rd_data;
                  state    <= ST_SP;
               end
            end
            ST_SP: state <= FETCH;
            FETCH: begin
               if (i_rd_valid) begin
                  inst <= i_rd_data;
                  // Dispatch on the word being fetched
                  case (i_rd_data[OPCODE_W-1:0])
                     OP_ALU_R, OP_ALU_I, OP_LOAD,
                     OP_STORE, OP_BRANCH, OP_JALR: state <= LD_RS1;
                     OP_JAL, OP_LUI, OP_AUIPC:     state <= WRITE_RD;
                     default:                      state <= FAULT;
                  endcase
               end
            end
            LD_RS1: begin
               if (i_rd_valid) begin
                  rs1_val <= i_rd_data;
                  case (i_opcode)
                     OP_ALU_R, OP_STORE, OP_BRANCH: state <= LD_RS2;
                     OP_LOAD:                       state <= LOAD;
                     default:                       state <= WRITE_RD;
                  endcase
               end
            end
            LD_RS2: begin
               if (i_rd_valid) begin
                  rs2_val <= i_rd_data;
                  case (i_opcode)
                     OP_STORE:  state <= STORE;
                     OP_BRANCH: state <= EXEC_BRANCH;
                     default:   state <= WRITE_RD;
                  endcase
               end
            end
            EXEC_BRANCH: begin
               pc    <= i_branch_taken ? pc + i_imm[ADDR_W-1:0] : pc_plus4;
               state <= FETCH;
            end
            LOAD: begin
               if (i_rd_valid) begin
                  mem_data <= i_rd_data;
                  state    <= WRITE_RD;
               end
            end
            WRITE_RD: begin
               case (i_opcode)
                  OP_JAL:  pc <= pc + i_imm[ADDR_W-1:0];
                  OP_JALR: pc <= {alu_addr[ADDR_W-1:1], 1'b0};
                  default: pc <= pc_plus4;
               endcase
               state <= FETCH;
            end
            STORE: begin
               pc    <= pc_plus4;
               state <= FETCH;
            end
            default: state <= FAULT;
         endcase
      end
   end

endmodule

//--- verif/cpu_checker.sv
// Memory port checker for the RV32I core
// Concurrent assertions on the strobes and address, bound into cpu_top
`timescale 1ns/10ps

module cpu_checker (
   input logic        clk,
   input logic        i_rst_n,
   input logic        o_rd_en,
   input logic        o_wr_en,
   input logic [15:0] o_addr,
   input logic        i_rd_valid
);

   // Read and write share o_addr
   a_one_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_rd_en && o_wr_en))
      else $error("read and write strobes high together");

   a_addr_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_rd_en && !i_rd_valid) |=> (o_rd_en && $stable(o_addr)))
      else $error("address moved while a read was pending");

   a_no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wr_en |-> (o_addr[15:2] != 14'd0))
      else $error("write to the x0 word");

   a_reset_quiet: assert property (@(posedge clk)
      !i_rst_n |=> (!o_rd_en && !o_wr_en))
      else $error("strobe high after reset");

endmodule

bind cpu_top cpu_checker u_checker (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .o_rd_en    (o_rd_en),
   .o_wr_en    (o_wr_en),
   .o_addr     (o_addr),
   .i_rd_valid (i_rd_valid)
);

//--- verif/cpu_tb.sv
// Testbench for the RV32I multicycle core
// Memory model with random read latency and directed program tests
`timescale 1ns/10ps

module cpu_tb
   import rv_isa_pkg::*, cpu_ctrl_pkg::*;
;

   localparam logic [31:0] SEED       = 32'h8b8b8622;
   localparam logic [15:0] PROG_BASE  = 16'h1000;
   // Three reads of up to three cycles plus one write or branch cycle
   localparam int          WORST_INST = 10;

   logic        clk = 1'b0;
   logic        i_rst_n = 1'b0;
   logic [31:0] i_rd_data = '0;
   logic        i_rd_valid = 1'b0;
   logic        o_rd_en;
   logic        o_wr_en;
   logic [15:0] o_addr;
   logic [31:0] o_wr_data;
   logic        o_fault;

   logic [31:0] mem [0:16383];
   logic        busy = 1'b0;
   int          wait_left = 0;
   int          cyc = 0;
   int          limit = 1000;
   int          rd_cnt = 0;
   int          wr_cnt = 0;
   int          halt_hits = 0;
   logic [15:0] first_fetch = '0;
   logic [15:0] halt_addr = '0;
   logic [15:0] load_ptr;
   int          prog_len;
   logic [4:0]  exp_reg [$];
   logic [31:0] exp_val [$];
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   cpu_top UUT (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_rd_en    (o_rd_en),
      .o_addr     (o_addr),
      .i_rd_data  (i_rd_data),
      .i_rd_valid (i_rd_valid),
      .o_wr_en    (o_wr_en),
      .o_wr_data  (o_wr_data),
      .o_fault    (o_fault)
   );

   always #2 clk = ~clk;

   // Write commit, read tracking and the cycle watchdog
   always @(posedge clk) begin
      if (!i_rst_n) begin
         cyc       = 0;
         rd_cnt    = 0;
         wr_cnt    = 0;
         halt_hits = 0;
      end else begin
         cyc = cyc + 1;
         if (o_wr_en) begin
            mem[o_addr[15:2]] = o_wr_data;
            wr_cnt = wr_cnt + 1;
         end
         if (o_rd_en && i_rd_valid) begin
            // Reads 0 and 1 are the vectors
            if (rd_cnt == 2)
               first_fetch = o_addr;
            if (o_addr == halt_addr)
               halt_hits = halt_hits + 1;
            rd_cnt = rd_cnt + 1;
         end
         if (cyc > limit) begin
            $display("Timeout after %0d cycles without reaching the end of the program", cyc);
            $display("Something failed");
            $finish;
         end
      end
   end

   // Read side of the memory, 0 to 2 wait cycles per read
   always @(posedge clk) begin
      #1;
      if (!i_rst_n) begin
         i_rd_valid = 1'b0;
         busy       = 1'b0;
      end else begin
         if (i_rd_valid) begin
            i_rd_valid = 1'b0;
            busy       = 1'b0;
         end
         if (o_rd_en && !busy) begin
            busy      = 1'b1;
            wait_left = int'($urandom % 3);
         end else if (busy && wait_left > 0) begin
            wait_left = wait_left - 1;
         end
         if (busy && wait_left == 0) begin
            i_rd_valid = 1'b1;
            i_rd_data  = mem[o_addr[15:2]];
         end
      end
   end

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_ALU_R};
   endfunction

   function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OP_STORE};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   // Reference results by the RV32I rules
   function automatic logic [31:0] alu_rule(logic alt, logic [2:0] f3, logic [31:0] a,
                                            logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic br_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic init_prog(logic [15:0] start, logic [31:0] sp);
      for (int i = 0; i < 16384; i++)
         mem[i] = {i[15:0] ^ 16'h3c5a, ~i[15:0]};
      for (int i = 0; i < 32; i++)
         mem[i] = '0;
      mem[VEC_RESET[15:2]] = {16'h0, start};
      mem[VEC_SP[15:2]]    = sp;
      load_ptr = start;
      prog_len = 0;
      exp_reg.delete();
      exp_val.delete();
   endtask

   task automatic put(logic [31:0] word);
      mem[load_ptr[15:2]] = word;
      load_ptr = load_ptr + 16'd4;
      prog_len = prog_len + 1;
   endtask

   task automatic expect_reg(logic [4:0] n, logic [31:0] v);
      exp_reg.push_back(n);
      exp_val.push_back(v);
   endtask

   task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s = 0x%h, expected 0x%h", name, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic pulse_reset();
      #1 i_rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1 i_rst_n = 1'b1;
      @(posedge clk);
      #1;
      if (o_rd_en || o_wr_en) begin
         $display("[ERROR] strobes rd_en/wr_en = 0x%h/0x%h after reset, expected 0x0",
                  o_rd_en, o_wr_en);
         errors = errors + 1;
      end
   endtask

   // Ends the program with a self-loop JAL and runs until it is fetched twice
   task automatic run_prog();
      halt_addr = load_ptr;
      put(enc_j(21'd0, 5'd0));
      pulse_reset();
      limit = BOOT_CYCLES + 20 + (prog_len + 4) * WORST_INST;
      while (halt_hits < 2)
         @(posedge clk);
      for (int k = 0; k < exp_reg.size(); k++)
         check_val($sformatf("x%0d", exp_reg[k]), mem[exp_reg[k]], exp_val[k]);
   endtask

   task automatic report(string name, int err_before);
      tests_run = tests_run + 1;
      if (errors != err_before) begin
         tests_failed = tests_failed + 1;
         $display("test %s: FAIL", name);
      end else begin
         $display("test %s: pass", name);
      end
   endtask

   task automatic test_boot();
      int e;
      e = errors;
      init_prog(16'h1400, 32'h0000_bee0);
      expect_reg(5'd2, 32'h0000_bee0);
      run_prog();
      check_val("first_fetch", {16'h0, first_fetch}, 32'h0000_1400);
      report("boot", e);
   endtask

   task automatic test_alu();
      int e;
      logic [2:0]  f3_list [10];
      logic        alt_list [10];
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      e = errors;
      f3_list  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
      alt_list = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      a = 32'hffff_fff0;
      b = 32'h0000_0003;
      init_prog(PROG_BASE, 32'h0000_f000);
      mem[5] = a;
      mem[6] = b;
      for (int k = 0; k < 10; k++) begin
         put(enc_r({1'b0, alt_list[k], 5'd0}, 5'd6, 5'd5, f3_list[k], 5'(10 + k)));
         expect_reg(5'(10 + k), alu_rule(alt_list[k], f3_list[k], a, b));
      end
      for (int k = 0; k < 10; k++) begin
         if (k == 1)
            continue;
         // Shifts use a shift amount of 4 and SRAI sets imm bit 10
         if (f3_list[k] == 3'd1 || f3_list[k] == 3'd5)
            imm = {21'd0, alt_list[k], 10'd4};
         else
            imm = 32'hffff_fff5;
         put(enc_i(imm[11:0], 5'd5, f3_list[k], 5'(20 + k), OP_ALU_I));
         expect_reg(5'(20 + k), alu_rule(alt_list[k], f3_list[k], a,
                                         (f3_list[k] == 3'd1 || f3_list[k] == 3'd5) ?
                                         32'd4 : imm));
      end
      put(enc_r(7'd0, 5'd6, 5'd5, 3'd0, 5'd0));
      expect_reg(5'd0, 32'd0);
      run_prog();
      report("alu", e);
   endtask

   task automatic test_mem();
      int e;
      e = errors;
      init_prog(PROG_BASE, 32'h0000_f000);
      mem[5] = 32'h0000_2000;
      mem[6] = 32'h1234_5678;
      mem[7] = 32'hcafe_f00d;
      mem[16'h2010 >> 2] = 32'ha5a5_5a5a;
      put(enc_s(12'd8, 5'd6, 5'd5));
      put(enc_s(12'hffc, 5'd7, 5'd5));
      put(enc_i(12'd8, 5'd5, 3'd2, 5'd10, OP_LOAD));
      put(enc_i(12'hffc, 5'd5, 3'd2, 5'd11, OP_LOAD));
      put(enc_i(12'd16, 5'd5, 3'd2, 5'd12, OP_LOAD));
      expect_reg(5'd10, 32'h1234_5678);
      expect_reg(5'd11, 32'hcafe_f00d);
      expect_reg(5'd12, 32'ha5a5_5a5a);
      run_prog();
      check_val("mem[0x2008]", mem[16'h2008 >> 2], 32'h1234_5678);
      check_val("mem[0x1ffc]", mem[16'h1ffc >> 2], 32'hcafe_f00d);
      report("load_store", e);
   endtask

   task automatic test_branch();
      int e;
      int m;
      logic [2:0]  br_list [6];
      logic [4:0]  ra_list [3];
      logic [4:0]  rb_list [3];
      logic [31:0] regs [8];
      e = errors;
      m = 10;
      br_list = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
      ra_list = '{5'd5, 5'd6, 5'd5};
      rb_list = '{5'd6, 5'd5, 5'd5};
      init_prog(PROG_BASE, 32'h0000_f000);
      regs[5] = 32'hffff_fff0;
      regs[6] = 32'h0000_0003;
      mem[5] = regs[5];
      mem[6] = regs[6];
      for (int i = 0; i < 6; i++) begin
         for (int j = 0; j < 3; j++) begin
            // Taken skips the marker ADDI
            put(enc_b(13'd8, rb_list[j], ra_list[j], br_list[i]));
            put(enc_i(12'd1, 5'd0, 3'd0, 5'(m), OP_ALU_I));
            expect_reg(5'(m), br_rule(br_list[i], regs[ra_list[j]], regs[rb_list[j]]) ?
                              32'd0 : 32'd1);
            m = m + 1;
         end
      end
      run_prog();
      report("branch", e);
   endtask

   task automatic test_jump();
      int e;
      logic [15:0] p;
      e = errors;
      init_prog(PROG_BASE, 32'h0000_f000);
      p = load_ptr;
      mem[5] = {16'h0, p + 16'd24};
      put({20'habcde, 5'd10, OP_LUI});
      put({20'h00001, 5'd11, OP_AUIPC});
      put(enc_j(21'd8, 5'd12));
      put(enc_i(12'd1, 5'd0, 3'd0, 5'd13, OP_ALU_I));
      put(enc_i(12'd1, 5'd5, 3'd0, 5'd14, OP_JALR));
      put(enc_i(12'd1, 5'd0, 3'd0, 5'd15, OP_ALU_I));
      expect_reg(5'd10, 32'habcd_e000);
      expect_reg(5'd11, {16'h0, p + 16'd4} + 32'h0000_1000);
      expect_reg(5'd12, {16'h0, p + 16'd12});
      expect_reg(5'd13, 32'd0);
      expect_reg(5'd14, {16'h0, p + 16'd20});
      expect_reg(5'd15, 32'd0);
      run_prog();
      report("jump", e);
   endtask

   task automatic test_fault();
      int e;
      int wr_before;
      e = errors;
      init_prog(PROG_BASE, 32'h0000_f000);
      put(enc_i(12'd7, 5'd0, 3'd0, 5'd10, OP_ALU_I));
      put(32'h0000_007f);
      put(enc_i(12'd5, 5'd0, 3'd0, 5'd11, OP_ALU_I));
      pulse_reset();
      limit = BOOT_CYCLES + 20 + (prog_len + 4) * WORST_INST + 40;
      while (!o_fault)
         @(posedge clk);
      wr_before = wr_cnt;
      repeat (20) @(posedge clk);
      #1;
      check_val("o_fault", {31'd0, o_fault}, 32'd1);
      check_val("wr_count", wr_cnt, wr_before);
      check_val("x10", mem[10], 32'd7);
      check_val("x11", mem[11], 32'd0);
      report("fault", e);
   endtask

   initial begin
      void'($urandom(SEED));
      test_boot();
      test_alu();
      test_mem();
      test_branch();
      test_jump();
      test_fault();
      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
